// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timescale 1ns/100ps -Wno-fatal --top-module arp_tb -f list.f
	./obj_dir/Varp_tb

clean:
	rm -rf obj_dir

// File: hdl/arp_mem.sv
module arp_mem #(
  parameter int addr_w = 3
) (
  input  logic                clk,
  input  logic [addr_w-1:0]   a_addr,
  input  logic [addr_w-1:0]   b_addr,
  input  logic                a_we,
  input  logic                b_we,
  input  arp_pkg::arp_entry_t a_wdata,
  input  arp_pkg::arp_entry_t b_wdata,
  output arp_pkg::arp_entry_t a_rdata,
  output arp_pkg::arp_entry_t b_rdata
);

  arp_pkg::arp_entry_t mem [2**addr_w];

  always_ff @(posedge clk) begin
    if (a_we) begin
      mem[a_addr] <= a_wdata;
    end
    if (b_we) begin
      mem[b_addr] <= b_wdata;
    end
    a_rdata <= mem[a_addr]; // read before write
    b_rdata <= mem[b_addr];
  end

endmodule

// File: hdl/arp_pkg.sv
package arp_pkg;

  typedef logic [3:0][7:0] ipv4_t; // byte 3 first on the wire
  typedef logic [5:0][7:0] mac_addr_t;

  typedef struct packed {
    mac_addr_t mac;
    ipv4_t     ipv4;
  } dev_t;

  typedef enum logic [15:0] {
    arp_request = 16'd1,
    arp_reply   = 16'd2
  } arp_oper_t;

  // wire order, first byte in the msb
  typedef struct packed {
    logic [15:0] hw_type;
    logic [15:0] proto;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    arp_oper_t   oper;
    mac_addr_t   src_mac;
    ipv4_t       src_ipv4;
    mac_addr_t   dst_mac;
    ipv4_t       dst_ipv4;
  } arp_hdr_t;

  typedef struct packed {
    logic [7:0]  dat;
    logic        val;
    logic        err;
    logic [15:0] ethertype;
  } mac_rx_t;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    mac_addr_t  dst_mac;
  } mac_tx_t;

  typedef struct packed {
    logic      val;
    ipv4_t     ipv4;
    mac_addr_t mac;
  } arp_learn_t;

  typedef struct packed {
    logic      valid;
    ipv4_t     ipv4;
    mac_addr_t mac;
  } arp_entry_t;

endpackage

// File: hdl/arp_rx.sv
`include "arp_defs.svh"

module arp_rx (
  input  logic                clk,
  input  logic                fsm_rst,
  input  arp_pkg::dev_t       dev,
  input  arp_pkg::mac_rx_t    rx,
  output arp_pkg::arp_learn_t learn,
  output arp_pkg::arp_hdr_t   reply_hdr,
  output logic                reply_req
);

  localparam int hdr_bytes   = `ARP_PKT_BYTES;
  localparam int frame_bytes = `ARP_FRAME_BYTES;

  logic [5:0]                 byte_cnt;
  logic [hdr_bytes-2:0][7:0]  shift_q; // last header byte comes straight from rx.dat
  logic                       full;    // 46 bytes seen, waiting for the end of frame
  logic                       skip;    // rest of a bad frame
  logic                       is_arp;
  logic                       frame_end;

  assign is_arp    = rx.ethertype == `ARP_ETHERTYPE;
  assign frame_end = full && !rx.val && !rx.err;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      byte_cnt <= '0;
      shift_q  <= '0;
      full     <= 1'b0;
      skip     <= 1'b0;
    end else if (!rx.val || rx.err || full || skip) begin
      // gap, error or 47th byte
      byte_cnt <= '0;
      shift_q  <= '0;
      full     <= 1'b0;
      skip     <= rx.val; // hold off until the gap
    end else if (is_arp) begin
      shift_q  <= {shift_q[hdr_bytes-3:0], rx.dat};
      byte_cnt <= byte_cnt + 6'd1;
      if (byte_cnt == 6'(frame_bytes - 1)) begin
        full <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!fsm_rst && rx.val && !rx.err && !full && !skip && is_arp &&
        byte_cnt == 6'(hdr_bytes - 1)) begin
      reply_hdr <= arp_pkg::arp_hdr_t'({shift_q, rx.dat});
    end
  end

  assign learn.val  = frame_end;
  assign learn.ipv4 = reply_hdr.src_ipv4;
  assign learn.mac  = reply_hdr.src_mac;

  // request aimed at us
  assign reply_req = frame_end &&
                     reply_hdr.oper == arp_pkg::arp_request &&
                     reply_hdr.dst_ipv4 == dev.ipv4;

endmodule

// File: hdl/arp_table.sv
`include "arp_defs.svh"

module arp_table #(
  parameter int addr_w        = 3,
  parameter int timeout_ticks = 2000
) (
  input  logic                clk,
  input  logic                fsm_rst,
  input  arp_pkg::dev_t       dev,
  input  arp_pkg::arp_learn_t learn,
  input  arp_pkg::ipv4_t      ipv4_req,
  output arp_pkg::mac_addr_t  mac_rsp,
  output logic                arp_val,
  output logic                arp_err,
  output arp_pkg::arp_hdr_t   req_hdr,
  output logic                send_req,
  input  logic                tx_free
);

  localparam int tw = $clog2(timeout_ticks + 1);

  typedef enum logic [2:0] {
    w_clear,
    w_idle,
    w_scan,
    w_upd,
    w_add
  } w_state_t;

  typedef enum logic [1:0] {
    r_idle,
    r_scan,
    r_wait_tx,
    r_wait_reply
  } r_state_t;

  w_state_t            w_state;
  r_state_t            r_state;
  logic [addr_w-1:0]   a_addr, a_prev, w_ptr;
  logic [addr_w-1:0]   b_addr, b_prev;
  logic                a_rd_ok, b_rd_ok; // rdata belongs to the prev address
  logic                a_we;
  arp_pkg::arp_entry_t a_wdata, a_rdata, b_rdata;
  arp_pkg::ipv4_t      cur_ipv4, req_ipv4, req_prev;
  arp_pkg::mac_addr_t  cur_mac;
  logic                pend, start_req, go;
  logic                a_hit, a_miss, b_hit, b_miss, reply_hit;
  logic [tw-1:0]       timer;

  arp_mem #(.addr_w(addr_w)) mem_inst (
    .clk     (clk),
    .a_addr  (a_addr),
    .b_addr  (b_addr),
    .a_we    (a_we),
    .b_we    (1'b0),
    .a_wdata (a_wdata),
    .b_wdata ('0),
    .a_rdata (a_rdata),
    .b_rdata (b_rdata)
  );

  assign a_hit  = w_state == w_scan && a_rd_ok && a_rdata.valid && a_rdata.ipv4 == cur_ipv4;
  assign a_miss = w_state == w_scan && a_rd_ok && !a_hit && a_prev == '1;

  assign a_we          = w_state == w_clear || w_state == w_upd || w_state == w_add;
  assign a_wdata.valid = w_state != w_clear; // clear writes invalid words
  assign a_wdata.ipv4  = cur_ipv4;
  assign a_wdata.mac   = cur_mac;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      w_state <= w_clear;
      a_addr  <= '0;
      a_prev  <= '0;
      a_rd_ok <= 1'b0;
      w_ptr   <= '0;
    end else begin
      case (w_state)
        w_clear: begin
          a_addr <= a_addr + 1'b1;
          if (a_addr == '1) begin
            w_state <= w_idle;
          end
        end
        w_idle: begin
          a_addr  <= '0;
          a_rd_ok <= 1'b0;
          if (learn.val) begin
            w_state <= w_scan;
          end
        end
        w_scan: begin
          a_addr  <= a_addr + 1'b1;
          a_prev  <= a_addr;
          a_rd_ok <= 1'b1;
          if (a_hit) begin
            a_addr  <= a_prev;
            w_state <= w_upd;
          end else if (a_miss) begin
            a_addr  <= w_ptr; // oldest added entry
            w_state <= w_add;
          end
        end
        w_upd: w_state <= w_idle;
        w_add: begin
          w_ptr   <= w_ptr + 1'b1;
          w_state <= w_idle;
        end
        default: w_state <= w_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (w_state == w_idle && learn.val) begin
      cur_ipv4 <= learn.ipv4;
      cur_mac  <= learn.mac;
    end
  end

  assign start_req = ipv4_req != req_prev && ipv4_req != '0;
  assign go        = (pend || start_req) && r_state == r_idle && w_state != w_clear;

  assign b_hit     = r_state == r_scan && b_rd_ok && b_rdata.valid && b_rdata.ipv4 == req_ipv4;
  assign b_miss    = r_state == r_scan && b_rd_ok && !b_hit && b_prev == '1;
  assign reply_hit = r_state == r_wait_reply && learn.val && learn.ipv4 == req_ipv4;
  assign send_req  = r_state == r_wait_tx && tx_free;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      r_state  <= r_idle;
      req_prev <= '0;
      pend     <= 1'b0;
      arp_val  <= 1'b0;
      arp_err  <= 1'b0;
      b_addr   <= '0;
      b_prev   <= '0;
      b_rd_ok  <= 1'b0;
      timer    <= '0;
    end else begin
      req_prev <= ipv4_req;
      pend     <= (pend || start_req) && !go;
      arp_err  <= 1'b0;
      case (r_state)
        r_idle: begin
          b_addr  <= '0;
          b_rd_ok <= 1'b0;
          if (go) begin
            arp_val <= 1'b0;
            r_state <= r_scan;
          end
        end
        r_scan: begin
          b_addr  <= b_addr + 1'b1;
          b_prev  <= b_addr;
          b_rd_ok <= 1'b1;
          if (b_hit) begin
            arp_val <= 1'b1;
            r_state <= r_idle;
          end else if (b_miss) begin
            r_state <= r_wait_tx;
          end
        end
        r_wait_tx: begin
          timer <= '0;
          if (send_req) begin
            r_state <= r_wait_reply;
          end
        end
        r_wait_reply: begin
          timer <= timer + 1'b1;
          if (reply_hit) begin
            arp_val <= 1'b1;
            r_state <= r_idle;
          end else if (timer == tw'(timeout_ticks - 1)) begin
            arp_err <= 1'b1;
            r_state <= r_idle;
          end
        end
        default: r_state <= r_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      req_ipv4 <= ipv4_req;
    end
    if (b_hit) begin
      mac_rsp <= b_rdata.mac;
    end else if (reply_hit) begin
      mac_rsp <= learn.mac;
    end
    if (b_miss) begin // broadcast request
      req_hdr.hw_type  <= `ARP_HW_ETH;
      req_hdr.proto    <= `ARP_PROTO_IPV4;
      req_hdr.hlen     <= `ARP_HLEN;
      req_hdr.plen     <= `ARP_PLEN;
      req_hdr.oper     <= arp_pkg::arp_request;
      req_hdr.src_mac  <= dev.mac;
      req_hdr.src_ipv4 <= dev.ipv4;
      req_hdr.dst_mac  <= '1;
      req_hdr.dst_ipv4 <= req_ipv4;
    end
  end

endmodule

// File: hdl/arp_top.sv
`include "arp_defs.svh"

module arp_top (
  input  logic               clk,
  input  logic               fsm_rst,
  input  arp_pkg::dev_t      dev,
  input  arp_pkg::mac_rx_t   rx,
  output arp_pkg::mac_tx_t   tx,
  input  arp_pkg::ipv4_t     ipv4_req,
  output arp_pkg::mac_addr_t mac_rsp,
  output logic               arp_val,
  output logic               arp_err
);

  arp_pkg::arp_learn_t learn;
  arp_pkg::arp_hdr_t   reply_hdr, reply_q, req_hdr, tx_hdr;
  logic                reply_req, reply_pend;
  logic                send_req, send, busy, tx_free;

  arp_rx rx_inst (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .dev       (dev),
    .rx        (rx),
    .learn     (learn),
    .reply_hdr (reply_hdr),
    .reply_req (reply_req)
  );

  arp_tx tx_inst (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .dev     (dev),
    .hdr     (tx_hdr),
    .send    (send),
    .tx      (tx),
    .busy    (busy)
  );

  arp_table #(
    .addr_w        (`ARP_TABLE_AW),
    .timeout_ticks (`ARP_TIMEOUT_TICKS)
  ) table_inst (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .dev      (dev),
    .learn    (learn),
    .ipv4_req (ipv4_req),
    .mac_rsp  (mac_rsp),
    .arp_val  (arp_val),
    .arp_err  (arp_err),
    .req_hdr  (req_hdr),
    .send_req (send_req),
    .tx_free  (tx_free)
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      reply_pend <= 1'b0;
    end else if (reply_req) begin
      reply_pend <= 1'b1; // newer reply replaces a pending one
    end else if (!busy) begin
      reply_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reply_req) begin
      reply_q.hw_type  <= `ARP_HW_ETH;
      reply_q.proto    <= reply_hdr.proto;
      reply_q.hlen     <= `ARP_HLEN;
      reply_q.plen     <= reply_hdr.plen;
      reply_q.oper     <= arp_pkg::arp_reply;
      reply_q.src_mac  <= dev.mac;
      reply_q.src_ipv4 <= dev.ipv4;
      reply_q.dst_mac  <= reply_hdr.src_mac;
      reply_q.dst_ipv4 <= reply_hdr.src_ipv4;
    end
  end

  // reply first, table request only when nothing waits
  assign tx_free = !busy && !reply_pend;
  assign send    = (reply_pend && !busy) || send_req;
  assign tx_hdr  = reply_pend ? reply_q : req_hdr;

endmodule

// File: hdl/arp_tx.sv
`include "arp_defs.svh"

module arp_tx (
  input  logic              clk,
  input  logic              fsm_rst,
  input  arp_pkg::dev_t     dev,
  input  arp_pkg::arp_hdr_t hdr,
  input  logic              send,
  output arp_pkg::mac_tx_t  tx,
  output logic              busy
);

  localparam int hdr_bytes   = `ARP_PKT_BYTES;
  localparam int frame_bytes = `ARP_FRAME_BYTES;

  typedef enum logic {
    tx_idle,
    tx_send
  } tx_state_t;

  tx_state_t                 state;
  logic [5:0]                byte_cnt;
  logic [hdr_bytes-1:0][7:0] shift_q;
  arp_pkg::mac_addr_t        dst_mac_q;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= tx_idle;
      byte_cnt <= '0;
    end else begin
      case (state)
        tx_idle: begin
          byte_cnt <= '0;
          if (send) begin
            state <= tx_send;
          end
        end
        tx_send: begin
          byte_cnt <= byte_cnt + 6'd1;
          if (byte_cnt == 6'(frame_bytes - 1)) begin
            state <= tx_idle;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // zeros shift in behind the header and form the pad
  always_ff @(posedge clk) begin
    if (state == tx_idle && send) begin
      shift_q   <= {`ARP_HW_ETH, hdr.proto, `ARP_HLEN, `ARP_PLEN, hdr.oper,
                    dev.mac, dev.ipv4, hdr.dst_mac, hdr.dst_ipv4};
      dst_mac_q <= hdr.dst_mac;
    end else if (state == tx_send) begin
      shift_q <= {shift_q[hdr_bytes-2:0], 8'h00};
    end
  end

  assign busy       = state == tx_send;
  assign tx.val     = busy;
  assign tx.dat     = shift_q[hdr_bytes-1];
  assign tx.dst_mac = dst_mac_q;

endmodule

// File: include/arp_defs.svh
`ifndef ARP_DEFS_SVH
`define ARP_DEFS_SVH

// table of 2**aw entries
`define ARP_TABLE_AW 3
`define ARP_TIMEOUT_TICKS 2000

`define ARP_PKT_BYTES 28
`define ARP_FRAME_BYTES 46 // packet plus zero pad

`define ARP_ETHERTYPE 16'h0806
`define ARP_PROTO_IPV4 16'h0800
`define ARP_HW_ETH 16'd1

// address lengths of an ethernet/ipv4 arp packet
`define ARP_HLEN 8'd6
`define ARP_PLEN 8'd4

`endif

// File: list.f
+incdir+include
hdl/arp_pkg.sv
hdl/arp_rx.sv
hdl/arp_tx.sv
hdl/arp_mem.sv
hdl/arp_table.sv
hdl/arp_top.sv
testbench/arp_tb.sv

// File: testbench/arp_tb.sv
`include "arp_defs.svh"

module arp_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int entries = 2**`ARP_TABLE_AW;

  logic               clk;
  logic               fsm_rst;
  arp_pkg::dev_t      dev;
  arp_pkg::mac_rx_t   rx;
  arp_pkg::mac_tx_t   tx;
  arp_pkg::ipv4_t     ipv4_req;
  arp_pkg::mac_addr_t mac_rsp;
  logic               arp_val;
  logic               arp_err;

  integer seed = 32'h344962c2;

  // table model, round robin like the DUT
  arp_pkg::ipv4_t     model_ip [entries];
  arp_pkg::mac_addr_t model_mac [entries];
  logic               model_ok [entries];
  int                 model_ptr = 0;

  arp_pkg::arp_hdr_t  exp_q [$]; // frames the DUT should send
  logic [7:0]         fbuf [64];
  int                 nbytes = 0;
  int                 frames_done = 0;
  arp_pkg::mac_addr_t first_dst;
  logic               dst_stable;

  arp_top uut (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .dev      (dev),
    .rx       (rx),
    .tx       (tx),
    .ipv4_req (ipv4_req),
    .mac_rsp  (mac_rsp),
    .arp_val  (arp_val),
    .arp_err  (arp_err)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic stop_sim();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic timed_out(input string what);
    $display("timed out at %0t ns while waiting for %s", $time, what);
    stop_sim();
  endtask

  task automatic check_hdr(input arp_pkg::arp_hdr_t got, input arp_pkg::arp_hdr_t exp,
                           input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
      stop_sim();
    end
  endtask

  task automatic check_mac(input arp_pkg::mac_addr_t got, input arp_pkg::mac_addr_t exp,
                           input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
      stop_sim();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %b expected %b", $time, what, got, exp);
      stop_sim();
    end
  endtask

  // expected tx header, sender is always the local device
  function automatic arp_pkg::arp_hdr_t expect_hdr(input arp_pkg::arp_oper_t oper,
                                                   input arp_pkg::mac_addr_t mac,
                                                   input arp_pkg::ipv4_t ip);
    arp_pkg::arp_hdr_t h;
    h.hw_type  = 16'd1;
    h.proto    = 16'h0800;
    h.hlen     = 8'd6;
    h.plen     = 8'd4;
    h.oper     = oper;
    h.src_mac  = dev.mac;
    h.src_ipv4 = dev.ipv4;
    h.dst_mac  = mac; // requester on a reply, broadcast on a request
    h.dst_ipv4 = ip;
    return h;
  endfunction

  function automatic arp_pkg::arp_hdr_t build_hdr(input arp_pkg::arp_oper_t oper,
                                                  input arp_pkg::mac_addr_t smac,
                                                  input arp_pkg::ipv4_t sip,
                                                  input arp_pkg::ipv4_t dip);
    arp_pkg::arp_hdr_t h;
    h = expect_hdr(oper, '0, dip);
    h.src_mac  = smac;
    h.src_ipv4 = sip;
    return h;
  endfunction

  function automatic arp_pkg::ipv4_t new_ipv4();
    arp_pkg::ipv4_t ip;
    ip    = $random(seed);
    ip[3] = 8'd10; // 10.x.x.x, never the device
    return ip;
  endfunction

  function automatic arp_pkg::mac_addr_t new_mac();
    logic [63:0]        r;
    arp_pkg::mac_addr_t mac;
    r         = {$random(seed), $random(seed)};
    mac       = r[47:0];
    mac[5][0] = 1'b0; // unicast
    return mac;
  endfunction

  function automatic int find_entry(input arp_pkg::ipv4_t ip);
    for (int i = 0; i < entries; i++) begin
      if (model_ok[i] && model_ip[i] == ip) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic learn_entry(input arp_pkg::ipv4_t ip, input arp_pkg::mac_addr_t mac);
    int idx;
    idx = find_entry(ip);
    if (idx < 0) begin
      idx       = model_ptr;
      model_ptr = (model_ptr + 1) % entries;
    end
    model_ok[idx]  = 1'b1;
    model_ip[idx]  = ip;
    model_mac[idx] = mac;
  endtask

  task automatic send_frame(input arp_pkg::arp_hdr_t h, input int len, input int err_at,
                            input logic [15:0] etype);
    logic [27:0][7:0] pkt;
    pkt = h;
    for (int i = 0; i < len; i++) begin
      @(posedge clk);
      #2;
      rx.val       = 1'b1;
      rx.err       = (i == err_at);
      rx.ethertype = etype;
      rx.dat       = (i < 28) ? pkt[27 - i] : 8'h00;
    end
    @(posedge clk);
    #2;
    rx = '0;
    repeat (20) @(posedge clk); // leave room for the learn
  endtask

  task automatic send_good(input arp_pkg::arp_hdr_t h);
    send_frame(h, `ARP_FRAME_BYTES, -1, `ARP_ETHERTYPE);
    learn_entry(h.src_ipv4, h.src_mac);
  endtask

  task automatic wait_frames(input int n);
    int t;
    t = 0;
    while (frames_done < n && t < 500) begin
      @(posedge clk);
      t++;
    end
    if (frames_done < n) begin
      timed_out("a tx frame");
    end
  endtask

  task automatic start_lookup(input arp_pkg::ipv4_t a);
    @(posedge clk);
    #2;
    ipv4_req = '0;
    @(posedge clk);
    #2;
    ipv4_req = a;
    @(posedge clk); // lookup starts here, arp_val drops
  endtask

  task automatic wait_result(output logic v, output logic e);
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!arp_val && !arp_err && t < 3000);
    if (!arp_val && !arp_err) begin
      timed_out("arp_val or arp_err");
    end
    v = arp_val;
    e = arp_err;
  endtask

  // model decides hit or miss, a miss gets no reply
  task automatic verify_lookup(input arp_pkg::ipv4_t a);
    int   idx;
    logic v;
    logic e;
    idx = find_entry(a);
    if (idx < 0) begin
      exp_q.push_back(expect_hdr(arp_pkg::arp_request, '1, a));
    end
    start_lookup(a);
    wait_result(v, e);
    if (idx >= 0) begin
      check_flag(v, 1'b1, "arp_val on hit");
      check_flag(e, 1'b0, "arp_err on hit");
      check_mac(mac_rsp, model_mac[idx], "mac_rsp on hit");
    end else begin
      check_flag(e, 1'b1, "arp_err after timeout");
      check_flag(v, 1'b0, "arp_val on timeout");
    end
    check_flag(exp_q.size() == 0, 1'b1, "all expected frames sent");
  endtask

  task automatic score_frame();
    logic [27:0][7:0]  pkt;
    logic              pad_zero;
    arp_pkg::arp_hdr_t exp;
    if (exp_q.size() == 0) begin
      $display("[ERROR] %0t ns: unexpected tx frame of %0d bytes", $time, nbytes);
      stop_sim();
    end else if (nbytes != `ARP_FRAME_BYTES) begin
      $display("[ERROR] %0t ns: tx frame of %0d bytes", $time, nbytes);
      stop_sim();
    end else begin
      exp      = exp_q.pop_front();
      pad_zero = 1'b1;
      for (int i = 0; i < `ARP_PKT_BYTES; i++) begin
        pkt[27 - i] = fbuf[i];
      end
      for (int i = `ARP_PKT_BYTES; i < `ARP_FRAME_BYTES; i++) begin
        pad_zero = pad_zero && fbuf[i] == 8'h00;
      end
      check_hdr(arp_pkg::arp_hdr_t'(pkt), exp, "tx header");
      check_flag(pad_zero, 1'b1, "pad bytes zero");
      check_flag(dst_stable, 1'b1, "dst_mac stable");
      check_mac(first_dst, exp.dst_mac, "tx dst_mac");
      frames_done++;
    end
  endtask

  // monitor, samples on the falling edge
  always @(negedge clk) begin
    if (fsm_rst) begin
      nbytes = 0;
    end else if (tx.val) begin
      if (nbytes == 0) begin
        first_dst  = tx.dst_mac;
        dst_stable = 1'b1;
      end else if (tx.dst_mac !== first_dst) begin
        dst_stable = 1'b0;
      end
      if (nbytes < 64) begin
        fbuf[nbytes] = tx.dat;
      end
      nbytes++;
    end else if (nbytes > 0) begin
      score_frame();
      nbytes = 0;
    end
  end

  initial begin
    arp_pkg::arp_hdr_t  h;
    arp_pkg::ipv4_t     ip_a;
    arp_pkg::ipv4_t     ip_b;
    arp_pkg::mac_addr_t mac_a;
    arp_pkg::ipv4_t     hosts [9];
    logic               v;
    logic               e;
    for (int i = 0; i < entries; i++) begin
      model_ok[i] = 1'b0;
    end
    fsm_rst  = 1'b1;
    dev.mac  = 48'h02_00_5e_10_20_30;
    dev.ipv4 = 32'hc0a8_0101;
    rx       = '0;
    ipv4_req = '0;
    repeat (5) @(posedge clk);
    #2;
    fsm_rst = 1'b0;
    repeat (entries + 4) @(posedge clk); // table clear

    // request to us gets a reply, to another host none
    ip_a  = new_ipv4();
    mac_a = new_mac();
    exp_q.push_back(expect_hdr(arp_pkg::arp_reply, mac_a, ip_a));
    send_good(build_hdr(arp_pkg::arp_request, mac_a, ip_a, dev.ipv4));
    wait_frames(1);
    ip_a  = new_ipv4();
    ip_b  = new_ipv4();
    mac_a = new_mac();
    send_good(build_hdr(arp_pkg::arp_request, mac_a, ip_a, ip_b));
    repeat (200) @(posedge clk);

    // miss, request, then the reply resolves it
    ip_b  = new_ipv4();
    mac_a = new_mac();
    exp_q.push_back(expect_hdr(arp_pkg::arp_request, '1, ip_b));
    start_lookup(ip_b);
    wait_frames(frames_done + 1);
    send_good(build_hdr(arp_pkg::arp_reply, mac_a, ip_b, dev.ipv4));
    wait_result(v, e);
    check_flag(v, 1'b1, "arp_val after reply");
    check_flag(e, 1'b0, "arp_err after reply");
    check_mac(mac_rsp, mac_a, "mac_rsp after reply");

    // learning, hits and an update
    for (int i = 0; i < 3; i++) begin
      hosts[i] = new_ipv4();
      send_good(build_hdr(arp_pkg::arp_reply, new_mac(), hosts[i], dev.ipv4));
    end
    for (int i = 0; i < 3; i++) begin
      verify_lookup(hosts[i]);
    end
    send_good(build_hdr(arp_pkg::arp_reply, new_mac(), hosts[0], dev.ipv4));
    verify_lookup(hosts[0]);

    // 9 new senders push out the first
    for (int i = 0; i < 9; i++) begin
      hosts[i] = new_ipv4();
      send_good(build_hdr(arp_pkg::arp_reply, new_mac(), hosts[i], dev.ipv4));
    end
    for (int i = 0; i < 9; i++) begin
      verify_lookup(hosts[i]);
    end

    verify_lookup(new_ipv4()); // timeout

    // bad frames, none learned and none answered
    ip_a  = new_ipv4();
    mac_a = new_mac();
    h     = build_hdr(arp_pkg::arp_request, mac_a, ip_a, dev.ipv4);
    send_frame(h, `ARP_FRAME_BYTES, 20, `ARP_ETHERTYPE);
    send_frame(h, `ARP_FRAME_BYTES + 1, -1, `ARP_ETHERTYPE);
    send_frame(h, 40, -1, `ARP_ETHERTYPE);
    send_frame(h, `ARP_FRAME_BYTES, -1, 16'h0800);
    repeat (200) @(posedge clk);
    verify_lookup(ip_a);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
